// File: common/dprx_consts.svh
// Shared constants for the DisplayPort receive video path.
// Included by the package and by any module that sizes logic from these values.
// Control codes are the K-symbol byte values after 8b/10b decode.

`ifndef DPRX_CONSTS_SVH
`define DPRX_CONSTS_SVH

// Link geometry
`define DPRX_LANES          4           // Main-link lanes
`define DPRX_SYM_W          9           // K flag plus data byte

// Video
`define DPRX_BPC            8           // Bits per component

// Control codes, K28.5 / K27.7 / K30.7 / K23.7
`define DPRX_K_BS           8'hBC       // Blanking start
`define DPRX_K_BE           8'hFB       // Blanking end
`define DPRX_K_FS           8'hFE       // Fill start
`define DPRX_K_FE           8'hF7       // Fill end

// Word FIFO between parser and unpacker, power of two
`define DPRX_FIFO_DEPTH     8

`endif

// File: common/dprx_pkg.sv
// Types shared by the DisplayPort receive video path.
// Modules take these in with a wildcard import in their header.
// One link symbol is read as data, as a control code or as VB-ID,
// depending on where in the stream it arrives.

`include "dprx_consts.svh"

package dprx_pkg;

    // Control codes seen with K set
    typedef enum logic [`DPRX_SYM_W-2:0] {
        CTL_BS = `DPRX_K_BS,
        CTL_BE = `DPRX_K_BE,
        CTL_FS = `DPRX_K_FS,
        CTL_FE = `DPRX_K_FE
    } ctl_code_t;

    // One decoded symbol, three ways to read it
    typedef union packed {
        struct packed {
            logic                       k;
            logic [`DPRX_SYM_W-2:0]     dat;
        } data;
        struct packed {
            logic                       k;
            ctl_code_t                  code;
        } ctl;
        struct packed {
            logic                       k;
            logic [3:0]                 rsvd;
            logic                       no_vid;     // No video stream
            logic                       interlace;
            logic                       field;      // Field id
            logic                       vblank;     // Vertical blanking
        } vbid;
    } lnk_sym_t;

    // One clock of link input, lane 0 in the low bits
    typedef struct packed {
        lnk_sym_t [`DPRX_LANES-1:0]     lane;
    } lnk_beat_t;

    // FIFO entry, one byte per lane plus line marks
    typedef struct packed {
        logic                           sof;
        logic                           eol;
        logic [`DPRX_LANES-1:0][7:0]    dat;
    } lane_word_t;

    // Output pixel, r in the top byte
    typedef struct packed {
        logic [`DPRX_BPC-1:0]           r;
        logic [`DPRX_BPC-1:0]           g;
        logic [`DPRX_BPC-1:0]           b;
    } rgb_px_t;

endpackage

// File: lnk/dprx_lnk_parser.sv
// Link symbol parser for the receive main link.
// Tracks BS/BE/FS/FE framing on lane 0, reads the VB-ID after each BS and
// forwards active-video beats as lane words. Each word waits in a hold
// register until the next data beat or the closing BS, which sets eol.
// push is a one-cycle strobe; the link side cannot be stalled.

`include "dprx_consts.svh"

module dprx_lnk_parser
    import dprx_pkg::*;
(
    input  wire             lnk_clk,        // Link clock
    input  wire             rst,            // Sync reset
    input  lnk_beat_t       lnk_beat,       // Symbols from all lanes

    output logic            push,           // Word strobe to FIFO
    output lane_word_t      wr_word,        // Word to FIFO
    output logic            vid_en          // Active video, BE to BS
);

typedef enum logic [1:0] {
    ST_BLANK,                               // Vertical or horizontal blanking
    ST_VBID,                                // Beat after BS carries VB-ID
    ST_ACTIVE,                              // Pixel data
    ST_STUFF                                // Between FS and FE
} prs_state_t;

prs_state_t     state;
lnk_sym_t       sym0;                       // Lane 0 decides the beat type
logic           is_k;
logic           is_bs;
logic           is_be;
logic           is_fs;
logic           is_fe;
logic           data_cap;                   // Active data beat this cycle
logic           pend_vb;                    // Last VB-ID had vblank set
logic           sof_due;                    // Next captured word opens a frame
lane_word_t     cap_word;
lane_word_t     hold;                       // One-word hold register
logic           hold_vld;

// All lanes carry the same code, so lane 0 is enough
assign sym0     = lnk_beat.lane[0];
assign is_k     = sym0.data.k;
assign is_bs    = is_k && (sym0.ctl.code == CTL_BS);
assign is_be    = is_k && (sym0.ctl.code == CTL_BE);
assign is_fs    = is_k && (sym0.ctl.code == CTL_FS);
assign is_fe    = is_k && (sym0.ctl.code == CTL_FE);
assign data_cap = (state == ST_ACTIVE) && !is_k;

// Word as it would be captured from this beat
always_comb
begin
    cap_word.sof = sof_due;
    cap_word.eol = 1'b0;                    // Only known once BS arrives
    for (int l = 0; l < `DPRX_LANES; l++)
    begin
        cap_word.dat[l] = lnk_beat.lane[l].data.dat;
    end
end

// Framing FSM and strobes
always_ff @(posedge lnk_clk)
begin
    if (rst)
    begin
        state    <= ST_BLANK;
        pend_vb  <= 1'b0;
        sof_due  <= 1'b0;
        hold_vld <= 1'b0;
        push     <= 1'b0;
        vid_en   <= 1'b0;
    end
    else
    begin
        push <= 1'b0;                       // Default no push

        // BS wins from any state, it also closes the line
        if (is_bs)
        begin
            state  <= ST_VBID;
            vid_en <= 1'b0;
            if (hold_vld)
            begin
                push     <= 1'b1;           // Flush last word with eol
                hold_vld <= 1'b0;
            end
        end
        else
        begin
            case (state)
                ST_VBID:
                begin
                    pend_vb <= sym0.vbid.vblank;
                    state   <= ST_BLANK;
                end

                ST_BLANK:
                begin
                    if (is_be)
                    begin
                        state   <= ST_ACTIVE;
                        vid_en  <= 1'b1;
                        sof_due <= pend_vb; // First line after vblank
                    end
                end

                ST_ACTIVE:
                begin
                    if (is_fs)
                    begin
                        state <= ST_STUFF;
                    end
                    else if (data_cap)
                    begin
                        hold_vld <= 1'b1;
                        sof_due  <= 1'b0;
                        push     <= hold_vld;   // Previous word now complete
                    end
                end

                ST_STUFF:
                begin
                    if (is_fe)
                        state <= ST_ACTIVE; // Stuffing bytes are dropped
                end

                default:
                    state <= ST_BLANK;
            endcase
        end
    end
end

// Hold and output words
always_ff @(posedge lnk_clk)
begin
    if (is_bs && hold_vld)
    begin
        wr_word.sof <= hold.sof;
        wr_word.eol <= 1'b1;                // Last word of the line
        wr_word.dat <= hold.dat;
    end
    else if (data_cap)
    begin
        if (hold_vld)
            wr_word <= hold;
        hold <= cap_word;
    end
end

endmodule

// File: rtl/dprx_word_fifo.sv
// First-word-fall-through FIFO of lane words between parser and unpacker.
// rd_word is valid whenever not_empty is high; pop takes the head word.
// A push into a full FIFO is lost and sets ovf until reset.

`include "dprx_consts.svh"

module dprx_word_fifo
    import dprx_pkg::*;
(
    input  wire             lnk_clk,        // Link clock
    input  wire             rst,            // Sync reset
    input  wire             push,           // Write strobe
    input  lane_word_t      wr_word,        // Write data
    input  wire             pop,            // Read strobe

    output lane_word_t      rd_word,        // Head word
    output logic            not_empty,      // Head word valid
    output logic            ovf             // Sticky overflow
);

localparam int DEPTH = `DPRX_FIFO_DEPTH;
localparam int AW    = $clog2(DEPTH);

lane_word_t         mem [DEPTH];            // Storage
logic [AW-1:0]      wr_ptr;
logic [AW-1:0]      rd_ptr;
logic [AW:0]        count;                  // One extra bit for full
logic               full;
logic               wr_ok;
logic               rd_ok;

assign full      = (count == (AW+1)'(DEPTH));
assign not_empty = (count != '0);
assign wr_ok     = push && !full;
assign rd_ok     = pop && not_empty;
assign rd_word   = mem[rd_ptr];             // Fall-through read

// Pointers, count and overflow flag
always_ff @(posedge lnk_clk)
begin
    if (rst)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        ovf    <= 1'b0;
    end
    else
    begin
        if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;        // Wraps at power of two
        if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;

        case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
        endcase

        if (push && full)
            ovf <= 1'b1;                    // Word lost
    end
end

// Storage write
always_ff @(posedge lnk_clk)
begin
    if (wr_ok)
        mem[wr_ptr] <= wr_word;
end

endmodule

// File: vid/dprx_pix_unpack.sv
// Pixel unpacker on the FIFO read side.
// Collects three lane words, hands them to an output bank and presents
// four RGB pixels from it, one per accepted transfer. Pixel l takes r, g
// and b from lane l of words 0, 1 and 2. Outputs hold while vid_rdy is low.

`include "dprx_consts.svh"

module dprx_pix_unpack
    import dprx_pkg::*;
(
    input  wire             lnk_clk,        // Link clock
    input  wire             rst,            // Sync reset
    input  lane_word_t      rd_word,        // FIFO head word
    input  wire             not_empty,      // FIFO head valid
    input  wire             vid_rdy,        // Sink ready

    output logic            pop,            // FIFO read strobe
    output logic            vid_sof,        // Start of frame
    output logic            vid_eol,        // End of line
    output rgb_px_t         vid_dat,        // Pixel
    output logic            vid_vld         // Pixel valid
);

localparam int             IW       = $clog2(`DPRX_LANES);
localparam logic [IW-1:0]  PIX_LAST = IW'(`DPRX_LANES - 1);

lane_word_t [2:0]   coll_bank;              // Words being collected
lane_word_t [2:0]   out_bank;               // Words being presented
logic [1:0]         coll_cnt;               // Words in collect bank
logic               coll_full;
logic               out_full;               // Output bank busy
logic [IW-1:0]      pix_idx;                // Pixel, also the lane
logic               move;                   // Collect to output bank
logic               accept;                 // Pixel taken by sink

assign coll_full = (coll_cnt == 2'd3);
assign pop       = not_empty && !coll_full;
assign move      = coll_full && !out_full;
assign accept    = out_full && vid_rdy;

// Lane pix_idx of each word gives one component
assign vid_dat.r = out_bank[0].dat[pix_idx];
assign vid_dat.g = out_bank[1].dat[pix_idx];
assign vid_dat.b = out_bank[2].dat[pix_idx];

assign vid_vld = out_full;
assign vid_sof = out_full && (pix_idx == '0) && out_bank[0].sof;
assign vid_eol = out_full && (pix_idx == PIX_LAST) && out_bank[2].eol;

// Fill count, bank state and pixel index
always_ff @(posedge lnk_clk)
begin
    if (rst)
    begin
        coll_cnt <= '0;
        out_full <= 1'b0;
        pix_idx  <= '0;
    end
    else
    begin
        if (move)
            coll_cnt <= '0;                 // Start next group
        else if (pop)
            coll_cnt <= coll_cnt + 1'b1;

        if (move)
        begin
            out_full <= 1'b1;
            pix_idx  <= '0;
        end
        else if (accept)
        begin
            pix_idx <= pix_idx + 1'b1;
            if (pix_idx == PIX_LAST)
                out_full <= 1'b0;           // Group done
        end
    end
end

// Bank contents
always_ff @(posedge lnk_clk)
begin
    if (pop)
        coll_bank[coll_cnt] <= rd_word;
    if (move)
        out_bank <= coll_bank;
end

endmodule

// File: rtl/dprx_top.sv
// Top level of the receive video path, all on the link clock.
// Parser output goes through the word FIFO into the pixel unpacker.
// The sink applies back-pressure through vid_rdy only; when it stalls long
// enough the FIFO fills and fifo_ovf flags the lost words.

module dprx_top
    import dprx_pkg::*;
(
    input  wire             lnk_clk,        // Link clock
    input  wire             rst,            // Sync reset
    input  lnk_beat_t       lnk_beat,       // Decoded link symbols
    input  wire             vid_rdy,        // Sink ready

    output logic            vid_sof,        // Start of frame
    output logic            vid_eol,        // End of line
    output rgb_px_t         vid_dat,        // Pixel
    output logic            vid_vld,        // Pixel valid
    output logic            lnk_vid_en,     // Active video
    output logic            fifo_ovf        // Sticky overflow
);

// Parser to FIFO
logic           push;
lane_word_t     wr_word;

// FIFO to unpacker
logic           pop;
lane_word_t     rd_word;
logic           not_empty;

dprx_lnk_parser lnk_parser_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .lnk_beat   (lnk_beat),
    .push       (push),
    .wr_word    (wr_word),
    .vid_en     (lnk_vid_en)
);

dprx_word_fifo word_fifo_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .push       (push),
    .wr_word    (wr_word),
    .pop        (pop),
    .rd_word    (rd_word),
    .not_empty  (not_empty),
    .ovf        (fifo_ovf)
);

dprx_pix_unpack pix_unpack_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .rd_word    (rd_word),
    .not_empty  (not_empty),
    .vid_rdy    (vid_rdy),
    .pop        (pop),
    .vid_sof    (vid_sof),
    .vid_eol    (vid_eol),
    .vid_dat    (vid_dat),
    .vid_vld    (vid_vld)
);

endmodule

// File: dv/dprx_tb.sv
// Testbench for the DisplayPort receive video path.
// Builds a table of link beats and sink ready levels from an LCG, applies it
// one beat per clock and compares every accepted pixel against pixels built
// by the four-lane mapping rule. A final line with the sink stalled drives
// the word FIFO into overflow. The first error stops the run.

`include "dprx_consts.svh"

module dprx_tb
    import dprx_pkg::*;
();

localparam int TAB_MAX = 128;

// One table row
typedef struct packed {
    lnk_beat_t  beat;
    logic       rdy;                        // Sink ready for this beat
    logic       en;                         // lnk_vid_en after this beat
    logic       ovf_chk;                    // fifo_ovf known at this point
    logic       ovf;                        // Expected fifo_ovf
} stim_t;

logic           lnk_clk;
logic           rst;
lnk_beat_t      lnk_beat;
logic           vid_rdy;
logic           vid_sof;
logic           vid_eol;
rgb_px_t        vid_dat;
logic           vid_vld;
logic           lnk_vid_en;
logic           fifo_ovf;

stim_t          tab [TAB_MAX];
int             tab_len;
int             ovf_start;                  // First row of the overflow line
rgb_px_t        exp_px [$];
logic           exp_sof [$];
logic           exp_eol [$];

logic [31:0]    lcg_state;
logic           en_model;                   // Video enable as the beats imply
logic           pend_vb;                    // Last VB-ID vblank bit
logic           rdy_low;                    // Sink held off while building
logic           ovf_chk_cur;
logic           ovf_exp_cur;

int             px_cnt;                     // Accepted pixels so far
int             cycles;
int             limit;                      // Zero until the table is built
logic           stalled;
rgb_px_t        held_px;
logic           held_sof;
logic           held_eol;

always #2 lnk_clk = ~lnk_clk;               // Period 4

dprx_top dprx_top_i
(
    .lnk_clk    (lnk_clk),
    .rst        (rst),
    .lnk_beat   (lnk_beat),
    .vid_rdy    (vid_rdy),
    .vid_sof    (vid_sof),
    .vid_eol    (vid_eol),
    .vid_dat    (vid_dat),
    .vid_vld    (vid_vld),
    .lnk_vid_en (lnk_vid_en),
    .fifo_ovf   (fifo_ovf)
);

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "first error, run stopped");
endtask

task automatic check_px(input string name, input rgb_px_t got, input rgb_px_t exp);
    if (got !== exp)
        report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
        report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
endtask

task automatic check_status(input logic en, input logic ovf, input logic exp_en,
                            input logic exp_ovf);
    if (en !== exp_en)
        report_error($sformatf("MISMATCH lnk_vid_en got %h expected %h", en, exp_en));
    else if (ovf !== exp_ovf)
        report_error($sformatf("MISMATCH fifo_ovf got %h expected %h", ovf, exp_ovf));
endtask

// LCG, upper bits are the better ones
function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
endfunction

function automatic lnk_beat_t data_beat(input logic [`DPRX_LANES-1:0][7:0] d);
    lnk_beat_t b;
    for (int l = 0; l < `DPRX_LANES; l++)
    begin
        b.lane[l].data.k   = 1'b0;
        b.lane[l].data.dat = d[l];
    end
    return b;
endfunction

function automatic lnk_beat_t ctl_beat(input logic [7:0] code);
    lnk_beat_t b;
    for (int l = 0; l < `DPRX_LANES; l++)
    begin
        b.lane[l].data.k   = 1'b1;          // Same code on every lane
        b.lane[l].data.dat = code;
    end
    return b;
endfunction

function automatic lnk_beat_t vbid_beat(input logic vb);
    lnk_beat_t b;
    for (int l = 0; l < `DPRX_LANES; l++)
    begin
        b.lane[l]             = '0;
        b.lane[l].vbid.vblank = vb;
    end
    return b;
endfunction

// Append one row, tracking the video enable the link implies
task automatic store_beat(input lnk_beat_t b);
    if (tab_len >= TAB_MAX)
        report_error("stimulus table is too small for the test sequence");
    else
    begin
        if (b.lane[0].data.k && b.lane[0].data.dat == `DPRX_K_BS)
            en_model = 1'b0;
        else if (b.lane[0].data.k && b.lane[0].data.dat == `DPRX_K_BE)
            en_model = 1'b1;
        tab[tab_len].beat    = b;
        tab[tab_len].rdy     = rdy_low ? 1'b0 : ((lcg_next() & 8'h03) != 8'h00);
        tab[tab_len].en      = en_model;
        tab[tab_len].ovf_chk = ovf_chk_cur;
        tab[tab_len].ovf     = ovf_exp_cur;
        tab_len++;
    end
endtask

task automatic idle_run(input int n);
    repeat (n)
        store_beat(data_beat('0));
endtask

// BS, its VB-ID and some blanking
task automatic blanking_start(input logic vb);
    store_beat(ctl_beat(`DPRX_K_BS));
    store_beat(vbid_beat(vb));
    pend_vb = vb;
    idle_run(3);
endtask

// BE and nwords data beats, stuffing after word stuff_at
task automatic active_line(input int nwords, input int stuff_at, input logic record);
    lane_word_t                     words [$];
    lane_word_t                     w;
    logic [`DPRX_LANES-1:0][7:0]    d;
    rgb_px_t                        px;
    store_beat(ctl_beat(`DPRX_K_BE));
    for (int i = 0; i < nwords; i++)
    begin
        for (int l = 0; l < `DPRX_LANES; l++)
            d[l] = lcg_next();
        store_beat(data_beat(d));
        w.sof = (i == 0) && pend_vb;        // First line after vblank
        w.eol = (i == nwords - 1);
        w.dat = d;
        words.push_back(w);
        if (i == stuff_at)
        begin
            store_beat(ctl_beat(`DPRX_K_FS));
            repeat (3)
            begin
                for (int l = 0; l < `DPRX_LANES; l++)
                    d[l] = lcg_next();
                store_beat(data_beat(d));   // Stuffing, must vanish
            end
            store_beat(ctl_beat(`DPRX_K_FE));
        end
    end
    // Pixel p takes r, g, b from lane p of three consecutive words
    if (record)
    begin
        for (int g = 0; g < words.size() / 3; g++)
        begin
            for (int p = 0; p < `DPRX_LANES; p++)
            begin
                px.r = words[3*g].dat[p];
                px.g = words[3*g+1].dat[p];
                px.b = words[3*g+2].dat[p];
                exp_px.push_back(px);
                exp_sof.push_back((p == 0) && words[3*g].sof);
                exp_eol.push_back((p == `DPRX_LANES - 1) && words[3*g+2].eol);
            end
        end
    end
endtask

task automatic status_after_beat(input int i);
    if (tab[i].ovf_chk)
        check_status(lnk_vid_en, fifo_ovf, tab[i].en, tab[i].ovf);
    else
        check_flag("lnk_vid_en", lnk_vid_en, tab[i].en);
endtask

// Drive rows first..last, checking status one cycle after each
task automatic apply_range(input int first, input int last);
    for (int i = first; i <= last; i++)
    begin
        @(posedge lnk_clk);
        #1;
        if (i > first)
            status_after_beat(i - 1);
        lnk_beat = tab[i].beat;
        vid_rdy  = tab[i].rdy;
    end
    @(posedge lnk_clk);
    #1;
    status_after_beat(last);
endtask

// Monitor at the falling edge, outputs settled
always @(negedge lnk_clk)
begin
    if (!rst)
    begin
        if (stalled)
        begin
            check_flag("vid_vld held", vid_vld, 1'b1);
            check_px("vid_dat held", vid_dat, held_px);
            check_flag("vid_sof held", vid_sof, held_sof);
            check_flag("vid_eol held", vid_eol, held_eol);
        end
        if (vid_vld && vid_rdy)
        begin
            if (px_cnt >= exp_px.size())
                report_error("a pixel was accepted beyond the expected stream");
            else
            begin
                check_px("vid_dat", vid_dat, exp_px[px_cnt]);
                check_flag("vid_sof", vid_sof, exp_sof[px_cnt]);
                check_flag("vid_eol", vid_eol, exp_eol[px_cnt]);
                px_cnt++;
            end
        end
        stalled  = vid_vld && !vid_rdy;
        held_px  = vid_dat;
        held_sof = vid_sof;
        held_eol = vid_eol;
    end
end

// Timeout
always @(posedge lnk_clk)
begin
    if (!rst)
        cycles++;
    if (limit != 0 && cycles > limit)
        report_error("the run timed out before all pixels were accepted");
end

initial
begin
    lnk_clk     = 1'b0;
    rst         = 1'b1;
    vid_rdy     = 1'b0;
    lnk_beat    = '0;
    px_cnt      = 0;
    cycles      = 0;
    limit       = 0;
    stalled     = 1'b0;
    lcg_state   = 32'd30;
    tab_len     = 0;
    en_model    = 1'b0;
    pend_vb     = 1'b0;
    rdy_low     = 1'b0;
    ovf_chk_cur = 1'b1;
    ovf_exp_cur = 1'b0;

    // Two 8-pixel lines, the first opens the frame and has stuffing
    idle_run(4);
    blanking_start(1'b1);
    active_line(6, 2, 1'b1);
    blanking_start(1'b0);
    active_line(6, -1, 1'b1);
    blanking_start(1'b0);
    idle_run(4);

    // Long line with the sink stalled, overflow timing left open
    ovf_start   = tab_len;
    rdy_low     = 1'b1;
    ovf_chk_cur = 1'b0;
    active_line(16, -1, 1'b0);
    blanking_start(1'b0);
    idle_run(2);
    ovf_chk_cur = 1'b1;
    ovf_exp_cur = 1'b1;                     // Sticky from here on
    idle_run(8);

    limit = tab_len + 4 * exp_px.size() + 64;

    repeat (16) @(posedge lnk_clk);
    #1;
    rst = 1'b0;

    apply_range(0, ovf_start - 1);

    // Drain all pixels before stalling the sink
    lnk_beat = data_beat('0);
    vid_rdy  = 1'b1;
    while (px_cnt < exp_px.size())
    begin
        @(posedge lnk_clk);
        #1;
    end

    apply_range(ovf_start, tab_len - 1);

    if (px_cnt != exp_px.size())
        report_error("the number of accepted pixels differs from the expected stream");
    else
    begin
        $display("All checks passed");
        $finish;
    end
end

endmodule

// File: compile.f
+incdir+common
common/dprx_pkg.sv
lnk/dprx_lnk_parser.sv
rtl/dprx_word_fifo.sv
vid/dprx_pix_unpack.sv
rtl/dprx_top.sv
dv/dprx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the receive video path testbench with Verilator and run it.
# A failing check ends the simulation with $fatal, so the exit status carries
# pass or fail back to the caller.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -f compile.f --top-module dprx_tb -o dprx_sim

./obj_dir/dprx_sim
